/* rtl/sha256_core.sv */
`timescale 1ns/1ps
`default_nettype none

module sha256_core (
   input  logic                     wb_clk_i,
   input  logic                     wb_rst_i,
   input  sha256_pkg::sha_ctrl_t    ctrl_i,
   input  sha256_pkg::sha_block_t   block_i,
   output sha256_pkg::sha_status_t  status_o,
   output sha256_pkg::sha_digest_t  digest_o
);

   import sha256_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ROUNDS,
      ST_FINAL
   } state_t;

   state_t            state_q;
   logic [5:0]        round_q;
   logic              digest_valid_q;
   sha_digest_t       digest_q;
   sha_digest_t       seed;
   logic              start;
   logic              advance;
   logic [DATA_W-1:0] w;
   logic [DATA_W-1:0] t1;
   logic [DATA_W-1:0] t2;
   logic [DATA_W-1:0] a_q, b_q, c_q, d_q;
   logic [DATA_W-1:0] e_q, f_q, g_q, h_q;

   // Commands only count while idle
   assign start   = (state_q == ST_IDLE) && (ctrl_i.init || ctrl_i.next);
   assign advance = (state_q == ST_ROUNDS);
   assign seed    = ctrl_i.init ? SHA_H_INIT : digest_q;   // Next chains on old digest

   sha256_w_sched u_w_sched (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .load_i    (start),
      .advance_i (advance),
      .block_i   (block_i),
      .w_o       (w)
   );

   assign t1 = h_q + big_sigma1(e_q) + ch(e_q, f_q, g_q) + sha_k(round_q) + w;
   assign t2 = big_sigma0(a_q) + maj(a_q, b_q, c_q);

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q        <= ST_IDLE;
         round_q        <= '0;
         digest_valid_q <= 1'b0;
         digest_q       <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (start) begin
                  state_q        <= ST_ROUNDS;
                  round_q        <= '0;
                  digest_valid_q <= 1'b0;
                  digest_q       <= seed;
               end
            end
            ST_ROUNDS: begin
               round_q <= round_q + 6'd1;
               if (round_q == 6'(NUM_ROUNDS - 1)) begin
                  state_q <= ST_FINAL;
               end
            end
            ST_FINAL: begin
               // Fold working variables into the chaining value
               digest_q[7]    <= digest_q[7] + a_q;
               digest_q[6]    <= digest_q[6] + b_q;
               digest_q[5]    <= digest_q[5] + c_q;
               digest_q[4]    <= digest_q[4] + d_q;
               digest_q[3]    <= digest_q[3] + e_q;
               digest_q[2]    <= digest_q[2] + f_q;
               digest_q[1]    <= digest_q[1] + g_q;
               digest_q[0]    <= digest_q[0] + h_q;
               digest_valid_q <= 1'b1;
               state_q        <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Working variables
   always_ff @(posedge wb_clk_i) begin
      if (start) begin
         a_q <= seed[7];
         b_q <= seed[6];
         c_q <= seed[5];
         d_q <= seed[4];
         e_q <= seed[3];
         f_q <= seed[2];
         g_q <= seed[1];
         h_q <= seed[0];
      end else if (advance) begin
         h_q <= g_q;
         g_q <= f_q;
         f_q <= e_q;
         e_q <= d_q + t1;
         d_q <= c_q;
         c_q <= b_q;
         b_q <= a_q;
         a_q <= t1 + t2;
      end
   end

   assign status_o.ready        = (state_q == ST_IDLE);
   assign status_o.digest_valid = digest_valid_q;
   assign digest_o              = digest_q;

endmodule

`default_nettype wire

/* rtl/sha256_pkg.sv */
`default_nettype none

package sha256_pkg;

   localparam int ADDR_W       = 5;
   localparam int DATA_W       = 32;
   localparam int NUM_ROUNDS   = 64;
   localparam int BLOCK_WORDS  = 16;
   localparam int DIGEST_WORDS = 8;

   // Word addresses
   localparam logic [ADDR_W-1:0] ADR_CTRL    = 5'd0;
   localparam logic [ADDR_W-1:0] ADR_BLOCK0  = 5'd1;   // 1 to 16
   localparam logic [ADDR_W-1:0] ADR_STATUS  = 5'd17;
   localparam logic [ADDR_W-1:0] ADR_DIGEST0 = 5'd18;  // 18 to 25 with H7 first

   typedef struct packed {
      logic next;
      logic init;
   } sha_ctrl_t;

   // Bit 0 ready and bit 1 digest_valid
   typedef struct packed {
      logic digest_valid;
      logic ready;
   } sha_status_t;

   typedef logic [BLOCK_WORDS-1:0][DATA_W-1:0]  sha_block_t;   // Word 0 in low bits
   typedef logic [DIGEST_WORDS-1:0][DATA_W-1:0] sha_digest_t;  // H0 in top word

   localparam logic [DATA_W-1:0] K_TAB [NUM_ROUNDS] = '{
      32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
      32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
      32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
      32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
      32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
      32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
      32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
      32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
      32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
      32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
      32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
      32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
      32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
      32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
      32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
      32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
   };

   localparam sha_digest_t SHA_H_INIT = {
      32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
      32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
   };

   function automatic logic [DATA_W-1:0] sha_k(input logic [5:0] idx);
      return K_TAB[idx];
   endfunction

   function automatic logic [DATA_W-1:0] rotr(input logic [DATA_W-1:0] x, input int n);
      return (x >> n) | (x << (DATA_W - n));
   endfunction

   function automatic logic [DATA_W-1:0] big_sigma0(input logic [DATA_W-1:0] x);
      return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
   endfunction

   function automatic logic [DATA_W-1:0] big_sigma1(input logic [DATA_W-1:0] x);
      return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
   endfunction

   function automatic logic [DATA_W-1:0] small_sigma0(input logic [DATA_W-1:0] x);
      return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
   endfunction

   function automatic logic [DATA_W-1:0] small_sigma1(input logic [DATA_W-1:0] x);
      return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
   endfunction

   function automatic logic [DATA_W-1:0] ch(input logic [DATA_W-1:0] x,
                                            input logic [DATA_W-1:0] y,
                                            input logic [DATA_W-1:0] z);
      return (x & y) ^ (~x & z);
   endfunction

   function automatic logic [DATA_W-1:0] maj(input logic [DATA_W-1:0] x,
                                             input logic [DATA_W-1:0] y,
                                             input logic [DATA_W-1:0] z);
      return (x & y) ^ (x & z) ^ (y & z);
   endfunction

endpackage

`default_nettype wire

/* rtl/sha256_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sha256_top (
   input  logic                           wb_clk_i,
   input  logic                           wb_rst_i,
   input  logic [sha256_pkg::ADDR_W-1:0]  wb_adr_i,
   input  logic [sha256_pkg::DATA_W-1:0]  wb_dat_i,
   input  logic                           wb_we_i,
   input  logic                           wb_stb_i,
   input  logic                           wb_cyc_i,
   output logic                           wb_ack_o,
   output logic [sha256_pkg::DATA_W-1:0]  wb_dat_o
);

   import sha256_pkg::*;

   sha_ctrl_t   ctrl;
   sha_block_t  block;
   sha_status_t status;
   sha_digest_t digest;

   sha256_wb_regs u_wb_regs (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_ack_o (wb_ack_o),
      .wb_dat_o (wb_dat_o),
      .ctrl_o   (ctrl),
      .block_o  (block),
      .status_i (status),
      .digest_i (digest)
   );

   sha256_core u_core (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .ctrl_i   (ctrl),
      .block_i  (block),
      .status_o (status),
      .digest_o (digest)
   );

endmodule

`default_nettype wire

/* rtl/sha256_w_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module sha256_w_sched (
   input  logic                           wb_clk_i,
   input  logic                           wb_rst_i,
   input  logic                           load_i,
   input  logic                           advance_i,
   input  sha256_pkg::sha_block_t         block_i,
   output logic [sha256_pkg::DATA_W-1:0]  w_o
);

   import sha256_pkg::*;

   sha_block_t        win_q;   // win_q[0] is W[t]
   logic [DATA_W-1:0] w_new;

   // W[t+16] from the window
   assign w_new = small_sigma1(win_q[14]) + win_q[9] + small_sigma0(win_q[1]) + win_q[0];

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         win_q <= '0;
      end else if (load_i) begin
         win_q <= block_i;
      end else if (advance_i) begin
         win_q <= {w_new, win_q[BLOCK_WORDS-1:1]};
      end
   end

   assign w_o = win_q[0];

endmodule

`default_nettype wire

/* rtl/sha256_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sha256_wb_regs (
   input  logic                           wb_clk_i,
   input  logic                           wb_rst_i,
   input  logic [sha256_pkg::ADDR_W-1:0]  wb_adr_i,
   input  logic [sha256_pkg::DATA_W-1:0]  wb_dat_i,
   input  logic                           wb_we_i,
   input  logic                           wb_stb_i,
   input  logic                           wb_cyc_i,
   output logic                           wb_ack_o,
   output logic [sha256_pkg::DATA_W-1:0]  wb_dat_o,
   output sha256_pkg::sha_ctrl_t          ctrl_o,
   output sha256_pkg::sha_block_t         block_o,
   input  sha256_pkg::sha_status_t        status_i,
   input  sha256_pkg::sha_digest_t        digest_i
);

   import sha256_pkg::*;

   logic              access;
   logic              wr_en;
   logic              rd_en;
   logic              wr_ctrl;
   logic              in_block;
   logic              in_digest;
   logic [3:0]        blk_idx;
   logic [2:0]        dig_idx;
   logic [DATA_W-1:0] rd_data;

   assign access  = wb_stb_i & wb_cyc_i;   // cyc only qualifies stb
   assign wr_en   = access & wb_we_i;
   assign rd_en   = access & ~wb_we_i;
   assign wr_ctrl = wr_en && (wb_adr_i == ADR_CTRL);

   assign in_block  = (wb_adr_i >= ADR_BLOCK0) &&
                      (wb_adr_i < ADR_BLOCK0 + ADDR_W'(BLOCK_WORDS));
   assign in_digest = (wb_adr_i >= ADR_DIGEST0) &&
                      (wb_adr_i < ADR_DIGEST0 + ADDR_W'(DIGEST_WORDS));
   assign blk_idx   = 4'(wb_adr_i - ADR_BLOCK0);
   assign dig_idx   = 3'(wb_adr_i - ADR_DIGEST0);

   // Block words and command pulses
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         block_o <= '0;
         ctrl_o  <= '0;
      end else begin
         if (wr_en && in_block) begin
            block_o[blk_idx] <= wb_dat_i;
         end
         ctrl_o.init <= wr_ctrl & wb_dat_i[0];
         ctrl_o.next <= wr_ctrl & wb_dat_i[1] & ~wb_dat_i[0];   // Init wins
      end
   end

   always_comb begin
      rd_data = '0;
      if (in_block) begin
         rd_data = block_o[blk_idx];
      end else if (wb_adr_i == ADR_STATUS) begin
         rd_data = DATA_W'(status_i);
      end else if (in_digest) begin
         rd_data = digest_i[dig_idx];   // H7 at the lowest address
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
      end else begin
         wb_ack_o <= access;
         if (rd_en) begin
            wb_dat_o <= rd_data;
         end
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f vlog.f --top-module tb_sha256_top

./obj_dir/Vtb_sha256_top 2>&1 | tee sim.log

if grep -qF "** PASS **" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

/* tb/tb_sha256_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sha256_top;

   // Register map word addresses
   localparam int ADR_CTRL    = 0;
   localparam int ADR_BLOCK0  = 1;
   localparam int ADR_STATUS  = 17;
   localparam int ADR_DIGEST0 = 18;

   localparam int TIMEOUT_CYCLES = 3000;
   localparam int POLL_LIMIT     = 80;

   // Padded blocks with word 0 in the low bits
   localparam logic [511:0] ABC_BLOCK = {32'h00000018, {14{32'h00000000}}, 32'h61626380};
   localparam logic [511:0] TWO_BLOCK1 = {
      32'h00000000, 32'h80000000, 32'h6e6f7071, 32'h6d6e6f70,
      32'h6c6d6e6f, 32'h6b6c6d6e, 32'h6a6b6c6d, 32'h696a6b6c,
      32'h68696a6b, 32'h6768696a, 32'h66676869, 32'h65666768,
      32'h64656667, 32'h63646566, 32'h62636465, 32'h61626364
   };
   localparam logic [511:0] TWO_BLOCK2 = {32'h000001c0, {15{32'h00000000}}};

   // Digests with H0 in the top word
   localparam logic [255:0] ABC_DIGEST = {
      32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
      32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
   };
   localparam logic [255:0] TWO_DIGEST = {
      32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
      32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
   };

   logic        wb_clk_i = 1'b0;
   logic        wb_rst_i;
   logic [4:0]  wb_adr_i;
   logic [31:0] wb_dat_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic        wb_ack_o;
   logic [31:0] wb_dat_o;

   int          seed = 32'h9328;
   int          cycle_cnt = 0;
   logic        prev_access = 1'b0;
   logic [31:0] rnd_words [16];
   logic [31:0] new_word;
   logic [31:0] rd;

   sha256_top dut_i (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_ack_o (wb_ack_o),
      .wb_dat_o (wb_dat_o)
   );

   always #50 wb_clk_i = ~wb_clk_i;

   task automatic stop_with_failure();
      $display("** FAIL **");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         stop_with_failure();
      end
   endtask

   always @(posedge wb_clk_i) begin
      cycle_cnt   <= cycle_cnt + 1;
      prev_access <= wb_stb_i & wb_cyc_i;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
         stop_with_failure();
      end
   end

   // Ack must follow each strobed cycle by exactly one cycle
   always @(negedge wb_clk_i) begin
      check_eq("ack_timing", {31'b0, prev_access}, {31'b0, wb_ack_o});
   end

   task automatic wait_ack();
      int n;
      n = 0;
      do begin
         @(posedge wb_clk_i);
         #1;
         n++;
      end while (!wb_ack_o && n < 4);
      if (!wb_ack_o) begin
         $display("No ack from the DUT within 4 cycles of a strobe");
         stop_with_failure();
      end
   endtask

   task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
      @(posedge wb_clk_i);
      #1;
      wb_adr_i = adr;
      wb_dat_i = data;
      wb_we_i  = 1'b1;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      wait_ack();
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
      @(posedge wb_clk_i);
      #1;
      wb_adr_i = adr;
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      wait_ack();
      data     = wb_dat_o;   // Valid while ack is high
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
   endtask

   task automatic load_block(input logic [511:0] blk);
      for (int i = 0; i < 16; i++) begin
         wb_write(5'(ADR_BLOCK0 + i), blk[i*32 +: 32]);
      end
   endtask

   task automatic wait_digest(input string name);
      int          start;
      logic [31:0] st;
      start = cycle_cnt;
      wb_read(5'(ADR_STATUS), st);
      while (!st[1]) begin
         if (cycle_cnt - start > POLL_LIMIT) begin
            $display("Hash in %s did not finish within %0d cycles", name, POLL_LIMIT);
            stop_with_failure();
         end
         wb_read(5'(ADR_STATUS), st);
      end
      check_eq({name, " status"}, 32'h3, st);
   endtask

   // Lowest digest address holds H7
   task automatic check_digest(input string name, input logic [255:0] expected);
      logic [31:0] val;
      for (int i = 0; i < 8; i++) begin
         wb_read(5'(ADR_DIGEST0 + i), val);
         check_eq($sformatf("%s digest word %0d", name, i), expected[i*32 +: 32], val);
      end
   endtask

   initial begin
      wb_rst_i = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      repeat (8) @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;

      // Reset state
      wb_read(5'(ADR_STATUS), rd);
      check_eq("reset_status", 32'h1, rd);
      for (int i = 0; i < 16; i++) begin
         wb_read(5'(ADR_BLOCK0 + i), rd);
         check_eq("reset_block", 32'h0, rd);
      end
      check_digest("reset", 256'h0);

      // Block readback and unmapped reads
      for (int i = 0; i < 16; i++) begin
         rnd_words[i] = $random(seed);
         wb_write(5'(ADR_BLOCK0 + i), rnd_words[i]);
      end
      for (int i = 0; i < 16; i++) begin
         wb_read(5'(ADR_BLOCK0 + i), rd);
         check_eq("block_readback", rnd_words[i], rd);
      end
      for (int a = 26; a < 32; a++) begin
         wb_read(5'(a), rd);
         check_eq("unmapped_read", 32'h0, rd);
      end

      load_block(ABC_BLOCK);
      wb_write(5'(ADR_CTRL), 32'h1);
      wait_digest("abc");
      check_digest("abc", ABC_DIGEST);

      // Two blocks chained with next
      load_block(TWO_BLOCK1);
      wb_write(5'(ADR_CTRL), 32'h1);
      wait_digest("two_block_first");
      load_block(TWO_BLOCK2);
      wb_write(5'(ADR_CTRL), 32'h2);
      wait_digest("two_block_second");
      check_digest("two_block", TWO_DIGEST);

      // Init drops the chaining value
      load_block(ABC_BLOCK);
      wb_write(5'(ADR_CTRL), 32'h1);
      wait_digest("reinit");
      check_digest("reinit", ABC_DIGEST);

      load_block(ABC_BLOCK);
      wb_write(5'(ADR_CTRL), 32'h1);
      wb_read(5'(ADR_STATUS), rd);
      check_eq("busy_status", 32'h0, rd);
      new_word = $random(seed);
      wb_write(5'(ADR_BLOCK0 + 4), new_word);
      wb_write(5'(ADR_CTRL), 32'h1);   // Ignored while busy
      wait_digest("busy");
      check_digest("busy", ABC_DIGEST);
      wb_read(5'(ADR_BLOCK0 + 4), rd);
      check_eq("busy_block_rewrite", new_word, rd);

      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
rtl/sha256_pkg.sv
rtl/sha256_w_sched.sv
rtl/sha256_core.sv
rtl/sha256_wb_regs.sv
rtl/sha256_top.sv
tb/tb_sha256_top.sv
